// File: videoPkg.sv
/*
 * Shared video definitions
 *  - lineStateE  phase of a line or frame for the timing generator
 *  - cPixelWidth width of one YUYV pixel word
 */
`default_nettype none

package videoPkg;

	//------------------------------------------------------------
	// Line and frame phases
	//------------------------------------------------------------
	// Horizontal and vertical machines walk the same order
	// SYNC first, so a new frame opens with the sync pulse
	typedef enum logic [1:0]
	{
		SYNC   = 2'd0,
		BACK   = 2'd1,
		ACTIVE = 2'd2,
		FRONT  = 2'd3
	} lineStateE;

	//------------------------------------------------------------
	// Pixel word
	//------------------------------------------------------------
	// YUYV packing
	// [7:0]  Y sample
	// [15:8] U or V, alternating per pixel
	localparam int cPixelWidth = 16;

endpackage

`default_nettype wire

// File: pixelFifo.sv
/*
 * Synchronous pixel FIFO
 *  - RAM with read and write pointers and a fill count
 *  - almost-full flag with a fixed margin
 *  - registered read data, held on a pop from empty
 */
`default_nettype none

module pixelFifo #(
	parameter int pFifoDepth  = 4096,
	parameter int pFullMargin = 16
)(
	input  wire                               iFCLK,
	input  wire                               iFRST,
	// Write side
	input  wire                               i_push,
	input  wire  [videoPkg::cPixelWidth-1:0]  i_data,
	output logic                              o_full,
	// Read side
	input  wire                               i_pop,
	output logic [videoPkg::cPixelWidth-1:0]  o_data
);

	import videoPkg::*;

	localparam int lpPtrW     = $clog2(pFifoDepth);
	localparam int lpCntW     = $clog2(pFifoDepth + 1);
	localparam int lpFullLevel = pFifoDepth - pFullMargin;

	logic [cPixelWidth-1:0] rRam [pFifoDepth];
	logic [lpPtrW-1:0]      rWrPtr;
	logic [lpPtrW-1:0]      rRdPtr;
	logic [lpCntW-1:0]      rCount;
	logic                   wPushOk;
	logic                   wPopOk;

	// Truly full drops the write, empty ignores the pop
	assign wPushOk = i_push && (rCount != lpCntW'(pFifoDepth));
	assign wPopOk  = i_pop && (rCount != '0);

	// Almost-full, source gets pFullMargin cycles to stop
	assign o_full = (rCount >= lpCntW'(lpFullLevel));

	//------------------------------------------------------------
	// Pointers and fill level
	//------------------------------------------------------------
	always_ff @(posedge iFCLK)
	begin
		if (iFRST)
		begin
			rWrPtr <= '0;
			rRdPtr <= '0;
			rCount <= '0;
		end
		else
		begin
			if (wPushOk)
				rWrPtr <= (rWrPtr == lpPtrW'(pFifoDepth - 1)) ? '0 : rWrPtr + 1'b1;
			if (wPopOk)
				rRdPtr <= (rRdPtr == lpPtrW'(pFifoDepth - 1)) ? '0 : rRdPtr + 1'b1;
			// Simultaneous push and pop leave the count alone
			if (wPushOk && !wPopOk)
				rCount <= rCount + 1'b1;
			else if (wPopOk && !wPushOk)
				rCount <= rCount - 1'b1;
		end
	end

	//------------------------------------------------------------
	// Storage and read register
	//------------------------------------------------------------
	always_ff @(posedge iFCLK)
	begin
		if (wPushOk)
			rRam[rWrPtr] <= i_data;
		// Underrun repeats the last word
		if (wPopOk)
			o_data <= rRam[rRdPtr];
	end

	// Source ignored o_full past the margin
	assert property (@(posedge iFCLK) disable iff (iFRST)
		!(i_push && (rCount == lpCntW'(pFifoDepth))));

	assert property (@(posedge iFCLK) disable iff (iFRST)
		rCount <= lpCntW'(pFifoDepth));

endmodule

`default_nettype wire

// File: videoStartGate.sv
/*
 * Display start gate
 *  - counts accepted pixel writes after reset
 *  - opens once pPrefill words are buffered, stays open until reset
 */
`default_nettype none

module videoStartGate #(
	parameter int pPrefill = 1920
)(
	input  wire  iFCLK,
	input  wire  iFRST,
	input  wire  i_pixelValid,
	input  wire  i_pixelFull,
	output logic o_timingRun
);

	localparam int lpCntW = $clog2(pPrefill + 1);

	logic [lpCntW-1:0] rCnt;
	logic              wAccept;

	// Same acceptance rule the source sees
	assign wAccept = i_pixelValid && !i_pixelFull;

	always_ff @(posedge iFCLK)
	begin
		if (iFRST)
		begin
			rCnt        <= '0;
			o_timingRun <= 1'b0;
		end
		else if (!o_timingRun && wAccept)
		begin
			rCnt <= rCnt + 1'b1;
			// pPrefill-th write opens the gate
			if (rCnt == lpCntW'(pPrefill - 1))
				o_timingRun <= 1'b1;
		end
	end

	// Once open, only reset closes it
	assert property (@(posedge iFCLK) $fell(o_timingRun) |-> $past(iFRST));

endmodule

`default_nettype wire

// File: videoTimingGen.sv
/*
 * Display timing generator
 *  - horizontal and vertical phase FSMs with down-counters
 *  - registered HSYNC, VSYNC and DE
 *  - early fetch-enable, one cycle ahead of DE
 */
`default_nettype none

module videoTimingGen #(
	parameter int pHActive = 1920,
	parameter int pHBack   = 148,
	parameter int pHSync   = 44,
	parameter int pHFront  = 88,
	parameter int pVActive = 1080,
	parameter int pVBack   = 36,
	parameter int pVSync   = 5,
	parameter int pVFront  = 4
)(
	input  wire  iFCLK,
	input  wire  i_rst,
	output logic o_hs,
	output logic o_vs,
	output logic o_de,
	output logic o_fetchDe
);

	import videoPkg::*;

	// Counter widths cover a whole line or frame, more than any phase
	localparam int lpHTotal = pHSync + pHBack + pHActive + pHFront;
	localparam int lpVTotal = pVSync + pVBack + pVActive + pVFront;
	localparam int lpHW     = $clog2(lpHTotal);
	localparam int lpVW     = $clog2(lpVTotal);

	lineStateE       rHState;
	lineStateE       rVState;
	logic [lpHW-1:0] rHCnt;
	logic [lpVW-1:0] rVCnt;
	logic            wLineEnd;

	// Last cycle of the front porch closes the line
	assign wLineEnd = (rHState == FRONT) && (rHCnt == '0);

	//------------------------------------------------------------
	// Horizontal phase FSM
	//------------------------------------------------------------
	always_ff @(posedge iFCLK)
	begin
		if (i_rst)
		begin
			rHState <= SYNC;
			rHCnt   <= lpHW'(pHSync - 1);
		end
		else if (rHCnt != '0)
			rHCnt <= rHCnt - 1'b1;
		else
		begin
			// Phase done, load length of the next one
			case (rHState)
				SYNC:
				begin
					rHState <= BACK;
					rHCnt   <= lpHW'(pHBack - 1);
				end
				BACK:
				begin
					rHState <= ACTIVE;
					rHCnt   <= lpHW'(pHActive - 1);
				end
				ACTIVE:
				begin
					rHState <= FRONT;
					rHCnt   <= lpHW'(pHFront - 1);
				end
				default:
				begin
					rHState <= SYNC;
					rHCnt   <= lpHW'(pHSync - 1);
				end
			endcase
		end
	end

	//------------------------------------------------------------
	// Vertical phase FSM, one step per line
	//------------------------------------------------------------
	always_ff @(posedge iFCLK)
	begin
		if (i_rst)
		begin
			rVState <= SYNC;
			rVCnt   <= lpVW'(pVSync - 1);
		end
		else if (wLineEnd)
		begin
			if (rVCnt != '0)
				rVCnt <= rVCnt - 1'b1;
			else
			begin
				case (rVState)
					SYNC:
					begin
						rVState <= BACK;
						rVCnt   <= lpVW'(pVBack - 1);
					end
					BACK:
					begin
						rVState <= ACTIVE;
						rVCnt   <= lpVW'(pVActive - 1);
					end
					ACTIVE:
					begin
						rVState <= FRONT;
						rVCnt   <= lpVW'(pVFront - 1);
					end
					default:
					begin
						rVState <= SYNC;
						rVCnt   <= lpVW'(pVSync - 1);
					end
				endcase
			end
		end
	end

	//------------------------------------------------------------
	// Outputs
	//------------------------------------------------------------
	// FSM position runs one cycle ahead of the pins
	assign o_fetchDe = (rHState == ACTIVE) && (rVState == ACTIVE);

	// Sync and DE delayed together so they stay aligned
	always_ff @(posedge iFCLK)
	begin
		if (i_rst)
		begin
			o_hs <= 1'b0;
			o_vs <= 1'b0;
			o_de <= 1'b0;
		end
		else
		begin
			o_hs <= (rHState == SYNC);
			o_vs <= (rVState == SYNC);
			o_de <= o_fetchDe;
		end
	end

	// Vertical phase only moves after FRONT, so a late DE never crosses it
	assert property (@(posedge iFCLK) disable iff (i_rst)
		o_de |-> (rVState == ACTIVE));

endmodule

`default_nettype wire

// File: videoPostProcess.sv
/*
 * Video output back end, top level
 *  - pixel FIFO on the write side
 *  - start gate holding off the display timing
 *  - timing generator popping the FIFO in step with DE
 */
`default_nettype none

module videoPostProcess #(
	// 1920x1080 timing
	parameter int pHActive    = 1920,
	parameter int pHBack      = 148,
	parameter int pHSync      = 44,
	parameter int pHFront     = 88,
	parameter int pVActive    = 1080,
	parameter int pVBack      = 36,
	parameter int pVSync      = 5,
	parameter int pVFront     = 4,
	// Buffering
	parameter int pFifoDepth  = 4096,
	parameter int pFullMargin = 16,
	parameter int pPrefill    = 1920
)(
	input  wire                               iFCLK,
	input  wire                               iFRST,
	// Pixel source, YUYV words
	input  wire  [videoPkg::cPixelWidth-1:0]  i_pixelData,
	input  wire                               i_pixelValid,
	output logic                              o_pixelFull,
	// Display side
	output logic                              o_hs,
	output logic                              o_vs,
	output logic                              o_de,
	output logic [videoPkg::cPixelWidth-1:0]  o_data
);

	logic wTimingRun;
	logic wTimingRst;
	logic wFetchDe;

	// Timing generator held in reset until the gate opens
	assign wTimingRst = iFRST | ~wTimingRun;

	//------------------------------------------------------------
	// Pixel buffer
	//------------------------------------------------------------
	pixelFifo #(
		.pFifoDepth  (pFifoDepth),
		.pFullMargin (pFullMargin)
	) u_pixelFifo (
		.iFCLK  (iFCLK),
		.iFRST  (iFRST),
		.i_push (i_pixelValid),
		.i_data (i_pixelData),
		.o_full (o_pixelFull),
		.i_pop  (wFetchDe),
		.o_data (o_data)
	);

	videoStartGate #(
		.pPrefill (pPrefill)
	) u_startGate (
		.iFCLK        (iFCLK),
		.iFRST        (iFRST),
		.i_pixelValid (i_pixelValid),
		.i_pixelFull  (o_pixelFull),
		.o_timingRun  (wTimingRun)
	);

	//------------------------------------------------------------
	// Display timing
	//------------------------------------------------------------
	// Fetch leads DE by one cycle to cover the FIFO read register
	videoTimingGen #(
		.pHActive (pHActive),
		.pHBack   (pHBack),
		.pHSync   (pHSync),
		.pHFront  (pHFront),
		.pVActive (pVActive),
		.pVBack   (pVBack),
		.pVSync   (pVSync),
		.pVFront  (pVFront)
	) u_timingGen (
		.iFCLK     (iFCLK),
		.i_rst     (wTimingRst),
		.o_hs      (o_hs),
		.o_vs      (o_vs),
		.o_de      (o_de),
		.o_fetchDe (wFetchDe)
	);

endmodule

`default_nettype wire

// File: tbClockGen.sv
/*
 * Testbench clock and reset source
 *  - free-running clock, 100 ns period by default
 *  - reset held for a fixed number of rising edges
 */
`default_nettype none

module tbClockGen #(
	parameter int pHalfPeriod = 50,
	parameter int pRstCycles  = 2
)(
	output logic o_clk,
	output logic o_rst
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		o_clk = 1'b0;
		forever
			#(pHalfPeriod) o_clk = ~o_clk;
	end

	// Released on a falling edge, away from the DUT's sampling edge
	initial
	begin
		o_rst = 1'b1;
		repeat (pRstCycles)
			@(posedge o_clk);
		@(negedge o_clk);
		o_rst = 1'b0;
	end

endmodule

`default_nettype wire

// File: tbVideoPostProcess.sv
/*
 * Testbench for the video output back end
 *  - pixel writer driven by a burst and gap table that honours o_pixelFull
 *  - display checker for pixel order, DE, sync widths and start timing
 *  - fill-level model for the almost-full flag
 */
`default_nettype none

module tbVideoPostProcess;

	timeunit 1ns;
	timeprecision 100ps;

	import videoPkg::*;

	// Small 8x4 raster
	localparam int cHActive    = 8;
	localparam int cHBack      = 2;
	localparam int cHSync      = 2;
	localparam int cHFront     = 2;
	localparam int cVActive    = 4;
	localparam int cVBack      = 1;
	localparam int cVSync      = 1;
	localparam int cVFront     = 1;
	localparam int cLineLen    = cHSync + cHBack + cHActive + cHFront;
	localparam int cFrameLines = cVSync + cVBack + cVActive + cVFront;
	localparam int cFifoDepth  = 16;
	localparam int cFullMargin = 2;
	localparam int cPrefill    = 8;
	localparam int cFullLevel  = cFifoDepth - cFullMargin;
	localparam int cFrames     = 3;
	localparam int cRows       = 20;
	localparam int cWaitLimit  = 500;
	localparam int cRunLimit   = 3000;
	localparam int unsigned cSeed = 32'h77e3_bf10;

	logic                   iFCLK;
	logic                   iFRST;
	logic [cPixelWidth-1:0] rPixelData;
	logic                   rPixelValid;
	logic                   wPixelFull;
	logic                   wHs;
	logic                   wVs;
	logic                   wDe;
	logic [cPixelWidth-1:0] wData;

	// Stimulus table with burst length, gap, write-until-full flag and expected writes
	int burstTab [cRows];
	int gapTab   [cRows];
	int fullTab  [cRows];
	int expTab   [cRows];

	logic [cPixelWidth-1:0] refQ [$];
	logic [7:0]             pixCnt;
	int                     errData;
	int                     errTiming;
	int                     errFlag;
	bit                     timedOut;

	tbClockGen #(
		.pHalfPeriod (50),
		.pRstCycles  (2)
	) u_clkGen (
		.o_clk (iFCLK),
		.o_rst (iFRST)
	);

	videoPostProcess #(
		.pHActive    (cHActive),
		.pHBack      (cHBack),
		.pHSync      (cHSync),
		.pHFront     (cHFront),
		.pVActive    (cVActive),
		.pVBack      (cVBack),
		.pVSync      (cVSync),
		.pVFront     (cVFront),
		.pFifoDepth  (cFifoDepth),
		.pFullMargin (cFullMargin),
		.pPrefill    (cPrefill)
	) u_dut (
		.iFCLK        (iFCLK),
		.iFRST        (iFRST),
		.i_pixelData  (rPixelData),
		.i_pixelValid (rPixelValid),
		.o_pixelFull  (wPixelFull),
		.o_hs         (wHs),
		.o_vs         (wVs),
		.o_de         (wDe),
		.o_data       (wData)
	);

	//------------------------------------------------------------
	// Pixel writer
	//------------------------------------------------------------
	// One table row with inputs changed on the falling edge only
	task automatic writeRow(input int burst, input int gap, input int untilFull,
		output int written);
		int stall;
		bit rowDone;
		written = 0;
		stall   = 0;
		rowDone = 1'b0;
		while (!rowDone)
		begin
			if (untilFull == 0 && written >= burst)
				rowDone = 1'b1;
			else
			begin
				@(negedge iFCLK);
				if (wPixelFull)
				begin
					// Hold off under back-pressure
					rPixelValid = 1'b0;
					stall++;
					if (untilFull != 0)
						rowDone = 1'b1;
					else if (stall > cWaitLimit)
					begin
						$display("writer gave up, o_pixelFull stayed high for %0d cycles", stall);
						timedOut = 1'b1;
						rowDone  = 1'b1;
					end
				end
				else if (untilFull != 0 && written >= 4 * cFifoDepth)
				begin
					$display("writer gave up, o_pixelFull never rose after %0d writes", written);
					rPixelValid = 1'b0;
					timedOut    = 1'b1;
					rowDone     = 1'b1;
				end
				else
				begin
					// Y from a running count and random U or V
					rPixelData  = {8'($urandom), pixCnt};
					rPixelValid = 1'b1;
					pixCnt++;
					refQ.push_back(rPixelData);
					written++;
					stall = 0;
				end
			end
		end
		repeat (gap)
		begin
			@(negedge iFCLK);
			rPixelValid = 1'b0;
		end
	endtask

	task automatic driveTable();
		int row;
		int written;
		row = 0;
		while (row < cRows && !timedOut)
		begin
			writeRow(burstTab[row], gapTab[row], fullTab[row], written);
			assert (timedOut || written == expTab[row])
			else
			begin
				errFlag++;
				$display("error at %0t: row %0d wrote %0d words, expected %0d",
					$time, row, written, expTab[row]);
			end
			row++;
		end
		@(negedge iFCLK);
		rPixelValid = 1'b0;
	endtask

	//------------------------------------------------------------
	// Display checker
	//------------------------------------------------------------
	// Rising-edge sampling sees the values of the cycle before
	task automatic checkDisplay();
		int cycle        = 0;
		int level        = 0;
		int pushNow      = 0;
		int pushPrev     = 0;
		int popPrev      = 0;
		int pushTotal    = 0;
		int prefillCycle = 0;
		int deRun        = 0;
		int hsRun        = 0;
		int vsRun        = 0;
		int deLines      = 0;
		int vsRises      = 0;
		int lastHsRise   = 0;
		int lastVsRise   = 0;
		bit sawHs        = 1'b0;
		bit sawDe        = 1'b0;
		bit prevDe       = 1'b0;
		bit prevHs       = 1'b0;
		bit prevVs       = 1'b0;
		logic [cPixelWidth-1:0] expData;
		while (vsRises <= cFrames && cycle < cRunLimit && !timedOut)
		begin
			@(posedge iFCLK);
			cycle++;
			if (cycle == 1)
			begin
				assert (!wHs && !wVs && !wDe && !wPixelFull)
				else
				begin
					errFlag++;
					$display("error at %0t: outputs not low after reset", $time);
				end
			end
			// Fill level model where last cycle's pop shows up as DE now
			popPrev = (wDe && level > 0) ? 1 : 0;
			level   = level + pushPrev - popPrev;
			pushNow = (rPixelValid && level != cFifoDepth) ? 1 : 0;
			assert (wPixelFull == (level >= cFullLevel))
			else
			begin
				errFlag++;
				$display("error at %0t: o_pixelFull %0b at fill level %0d",
					$time, wPixelFull, level);
			end

			// Pixel order and prefill
			if (wDe)
			begin
				assert (pushTotal >= cPrefill && refQ.size() > 0)
				else
				begin
					errData++;
					$display("error at %0t: DE after only %0d writes", $time, pushTotal);
				end
				if (refQ.size() > 0)
				begin
					expData = refQ.pop_front();
					assert (wData == expData)
					else
					begin
						errData++;
						$display("error at %0t: o_data %h, expected %h", $time, wData, expData);
					end
				end
			end
			pushTotal += pushNow;
			if (pushNow == 1 && pushTotal == cPrefill)
				prefillCycle = cycle;

			// DE spans and first active pixel
			if (wDe && !prevDe && !sawDe)
			begin
				sawDe = 1'b1;
				assert (cycle == prefillCycle + 2 + (cVSync + cVBack) * cLineLen
					+ cHSync + cHBack)
				else
				begin
					errTiming++;
					$display("error at %0t: first DE at cycle %0d", $time, cycle);
				end
			end
			if (wDe)
				deRun++;
			else if (prevDe)
			begin
				assert (deRun == cHActive)
				else
				begin
					errTiming++;
					$display("error at %0t: DE run of %0d cycles", $time, deRun);
				end
				deLines++;
				deRun = 0;
			end

			// HSYNC start, period and width
			if (wHs && !prevHs)
			begin
				assert (sawHs ? (cycle - lastHsRise == cLineLen) : (cycle == prefillCycle + 2))
				else
				begin
					errTiming++;
					$display("error at %0t: HSYNC rose at cycle %0d", $time, cycle);
				end
				sawHs      = 1'b1;
				lastHsRise = cycle;
			end
			if (wHs)
				hsRun++;
			else if (prevHs)
			begin
				assert (hsRun == cHSync)
				else
				begin
					errTiming++;
					$display("error at %0t: HSYNC width %0d", $time, hsRun);
				end
				hsRun = 0;
			end

			// VSYNC closes a frame
			if (wVs && !prevVs)
			begin
				vsRises++;
				if (vsRises > 1)
				begin
					assert (deLines == cVActive && cycle - lastVsRise == cFrameLines * cLineLen)
					else
					begin
						errTiming++;
						$display("error at %0t: frame of %0d cycles with %0d DE lines",
							$time, cycle - lastVsRise, deLines);
					end
				end
				deLines    = 0;
				lastVsRise = cycle;
			end
			if (wVs)
				vsRun++;
			else if (prevVs)
			begin
				assert (vsRun == cVSync * cLineLen)
				else
				begin
					errTiming++;
					$display("error at %0t: VSYNC width %0d cycles", $time, vsRun);
				end
				vsRun = 0;
			end

			prevDe   = wDe;
			prevHs   = wHs;
			prevVs   = wVs;
			pushPrev = pushNow;
		end
		if (!timedOut && vsRises <= cFrames)
		begin
			$display("checker gave up, saw %0d VSYNC pulses in %0d cycles", vsRises, cycle);
			timedOut = 1'b1;
		end
	endtask

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------
	initial
	begin
		int rstWait;
		void'($urandom(cSeed));
		rPixelData  = '0;
		rPixelValid = 1'b0;
		pixCnt      = '0;
		errData     = 0;
		errTiming   = 0;
		errFlag     = 0;
		timedOut    = 1'b0;
		// Row 2 fills from 10 words to the almost-full level before any pop
		burstTab = '{8, 2, 0, 6, 5, 7, 4, 8, 3, 6, 8, 5, 7, 4, 8, 6, 5, 8, 8, 7};
		gapTab   = '{2, 4, 1, 1, 3, 0, 2, 1, 3, 2, 0, 1, 2, 1, 3, 0, 2, 1, 2, 1};
		fullTab  = '{0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
		expTab   = '{8, 2, 4, 6, 5, 7, 4, 8, 3, 6, 8, 5, 7, 4, 8, 6, 5, 8, 8, 7};

		rstWait = 0;
		@(posedge iFCLK);
		while (iFRST && rstWait < cWaitLimit)
		begin
			@(posedge iFCLK);
			rstWait++;
		end
		if (iFRST)
		begin
			$display("reset was never released");
			timedOut = 1'b1;
		end
		else
		begin
			fork
				driveTable();
				checkDisplay();
			join
		end

		$display("summary: %0d data errors, %0d timing errors, %0d flag errors",
			errData, errTiming, errFlag);
		if (!timedOut && errData + errTiming + errFlag == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
videoPkg.sv
pixelFifo.sv
videoStartGate.sv
videoTimingGen.sv
videoPostProcess.sv
tbClockGen.sv
tbVideoPostProcess.sv

// File: Makefile
# Verilator build for the video output back end
TOP = tbVideoPostProcess

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
